//--- Makefile
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f project.f --top-module tb_core -o Vtb_core

run: build
	./obj_dir/Vtb_core | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

lint:
	verilator --lint-only --timing -f project.f --top-module tb_core
	verilator --lint-only -Ihdl hdl/fetch_pkg.sv hdl/exec_pkg.sv hdl/fetch_queue.sv \
		hdl/decode_issue.sv hdl/branch_exec.sv hdl/pipeline_ctrl.sv \
		hdl/commit_stage.sv hdl/core_top.sv --top-module core_top

clean:
	rm -rf obj_dir $(LOG)

//--- bench/prog_gen.svh
`ifndef PROG_GEN_SVH
`define PROG_GEN_SVH

`include "cpu_defs_consts.svh"

`define PROG_KEY 32'h104584fe // program content key, same value as the stimulus seed

// scrambles a word index of the 64-word program space
function automatic logic [31:0] mix_word(input logic [5:0] word, input logic [31:0] key);
	logic [31:0] h;
	h = ({26'd0, word} + 32'd1) * 32'h9e3779b1;
	h = h ^ key;
	h = h ^ (h >> 15);
	h = h * 32'h85ebca6b;
	h = h ^ (h >> 13);
	return h;
endfunction

function automatic logic is_ctl_instr(input logic [31:0] instr);
	return (instr[31:26] == `OP_BEQ) || (instr[31:26] == `OP_BNE) ||
		(instr[31:26] == `OP_J);
endfunction

function automatic logic [31:0] raw_instr(input logic [31:0] pc);
	logic [31:0] h;
	logic [5:0] op;
	h = mix_word(pc[7:2], `PROG_KEY);
	case (h[3:0])
		4'd0, 4'd1: op = `OP_BEQ;
		4'd2: op = `OP_BNE;
		4'd3: op = `OP_J;
		4'd4: op = `OP_MUL;
		4'd5, 4'd6: op = `OP_LW;
		4'd7: op = (h[9:8] == 2'd0) ? `OP_SYNC : 6'h00;
		default: op = 6'h00;
	endcase
	if (op == `OP_J) begin
		return {op, 20'd0, h[29:24]}; // jump into the low program words
	end
	// narrow rs/rt fields so that equal pairs are common
	return {op, 3'd0, h[17:16], 3'd0, h[19:18], {11{h[24]}}, h[24:20]};
endfunction

// a delay slot never holds a branch or jump
function automatic logic [31:0] prog_instr(input logic [31:0] pc);
	logic [31:0] prev;
	logic [31:0] cur;
	prev = raw_instr(pc - 32'd4);
	cur = raw_instr(pc);
	if (is_ctl_instr(prev)) begin
		return {6'h00, cur[25:0]};
	end
	return cur;
endfunction

function automatic logic ctl_taken(input logic [31:0] instr);
	if (instr[31:26] == `OP_J) begin
		return 1'b1;
	end
	if (instr[31:26] == `OP_BNE) begin
		return instr[25:21] != instr[20:16];
	end
	return instr[25:21] == instr[20:16];
endfunction

function automatic logic [31:0] ctl_dest(input logic [31:0] pc, input logic [31:0] instr);
	logic [31:0] pc4;
	pc4 = pc + 32'd4;
	if (instr[31:26] == `OP_J) begin
		return {pc4[31:28], instr[25:0], 2'b00};
	end
	return pc4 + {{14{instr[15]}}, instr[15:0], 2'b00};
endfunction

`endif

//--- bench/core_checker.sv
`include "prog_gen.svh"
`timescale 1ns/1ps

module core_checker #(
	parameter int TARGET = 400
) (
	input  logic clk_i,
	input  logic rst_i,
	input  logic fetch_hs_i,
	input  logic redirect_valid_i,
	input  logic [1:0] commit_valid_i,
	input  logic [31:0] commit_pc0_i,
	input  logic [31:0] commit_pc1_i,
	output int errors_o,
	output int commits_o,
	output logic done_o
);

	logic [31:0] ref_pc;
	logic ref_pend; // a taken branch waits for its delay slot
	logic [31:0] ref_tgt;
	logic fetched;

	// next pc of sequential execution with one delay slot
	function automatic logic [31:0] ref_next(input logic [31:0] pc, input logic pend_i,
		input logic [31:0] tgt_i, output logic pend_o, output logic [31:0] tgt_o);
		logic [31:0] instr;
		logic [31:0] npc;
		instr = prog_instr(pc);
		npc = pend_i ? tgt_i : pc + 32'd4;
		pend_o = 1'b0;
		tgt_o = tgt_i;
		if (is_ctl_instr(instr) && ctl_taken(instr)) begin
			pend_o = 1'b1;
			tgt_o = ctl_dest(pc, instr);
		end
		return npc;
	endfunction

	task automatic check_lane(input int lane, input logic [31:0] got);
		if (got !== ref_pc) begin
			errors_o++;
			$display("[FAIL] %0t commit_pc%0d_o: got %h expected %h", $time, lane, got, ref_pc);
		end
		ref_pc = ref_next(ref_pc, ref_pend, ref_tgt, ref_pend, ref_tgt);
		commits_o++;
	endtask

	initial begin
		errors_o = 0;
		commits_o = 0;
		done_o = 1'b0;
		ref_pc = 32'd0; // fetch starts at pc 0
		ref_pend = 1'b0;
		ref_tgt = 32'd0;
		fetched = 1'b0;
	end

	// ##################################################
	// outputs are stable at the falling edge
	always @(negedge clk_i) begin
		if (rst_i || !fetched) begin
			if (commit_valid_i !== 2'b00 || redirect_valid_i !== 1'b0) begin
				errors_o++;
				$display("%0t commit or redirect active before the first fetch", $time);
			end
			if (!rst_i && fetch_hs_i === 1'b1) begin
				fetched = 1'b1;
			end
		end else if (!done_o) begin
			if (redirect_valid_i === 1'b1 && fetch_hs_i === 1'b1) begin
				errors_o++;
				$display("%0t fetch accepted in a redirect cycle", $time);
			end
			if ($isunknown(commit_valid_i)) begin
				errors_o++;
				$display("%0t commit_valid_o is unknown", $time);
			end else begin
				if (commit_valid_i[0]) begin
					check_lane(0, commit_pc0_i); // lane 0 is older
				end
				if (commit_valid_i[1]) begin
					check_lane(1, commit_pc1_i);
				end
			end
			if (commits_o >= TARGET) begin
				done_o = 1'b1;
			end
		end
	end

endmodule

//--- bench/tb_core.sv
`include "prog_gen.svh"
`timescale 1ns/1ps

module tb_core;

	localparam int TARGET = 400; // commits to check
	localparam int RST_CYCLES = 16;

	logic clk;
	logic rst;
	logic ifetch_valid;
	logic ifetch_ready;
	logic [31:0] ifetch_pc;
	logic [31:0] ifetch_instr;
	logic ifetch_pred_taken;
	logic [31:0] ifetch_pred_target;
	logic redirect_valid;
	logic [31:0] redirect_pc;
	logic mem_wait;
	logic [1:0] commit_valid;
	logic [31:0] commit_pc0;
	logic [31:0] commit_pc1;
	integer seed;
	int errors;
	int commits;
	logic chk_done;
	logic hs_s; // handshake seen in the last cycle
	logic rd_s;
	logic [31:0] rpc_s;
	logic pend; // port holds the delay slot of a predicted taken branch
	logic [31:0] ptgt;

	core_top i_dut (
		.clk_i(clk),
		.rst_i(rst),
		.ifetch_valid_i(ifetch_valid),
		.ifetch_ready_o(ifetch_ready),
		.ifetch_pc_i(ifetch_pc),
		.ifetch_instr_i(ifetch_instr),
		.ifetch_pred_taken_i(ifetch_pred_taken),
		.ifetch_pred_target_i(ifetch_pred_target),
		.redirect_valid_o(redirect_valid),
		.redirect_pc_o(redirect_pc),
		.mem_wait_i(mem_wait),
		.commit_valid_o(commit_valid),
		.commit_pc0_o(commit_pc0),
		.commit_pc1_o(commit_pc1)
	);

	core_checker #(.TARGET(TARGET)) i_chk (
		.clk_i(clk),
		.rst_i(rst),
		.fetch_hs_i(ifetch_valid & ifetch_ready),
		.redirect_valid_i(redirect_valid),
		.commit_valid_i(commit_valid),
		.commit_pc0_i(commit_pc0),
		.commit_pc1_i(commit_pc1),
		.errors_o(errors),
		.commits_o(commits),
		.done_o(chk_done)
	);

	always #5 clk = ~clk;

	// put one pc on the fetch port with a fresh prediction
	task automatic present_pc(input logic [31:0] pc);
		logic [31:0] ins;
		logic [31:0] r;
		ins = prog_instr(pc);
		r = $random(seed);
		ifetch_valid = 1'b1;
		ifetch_pc = pc;
		ifetch_instr = ins;
		ifetch_pred_taken = is_ctl_instr(ins) & r[0];
		ifetch_pred_target = r[1] ? ctl_dest(pc, ins) : ctl_dest(pc, ins) + 32'h40;
	endtask

	task automatic advance_fetch();
		logic [31:0] npc;
		npc = pend ? ptgt : ifetch_pc + 32'd4;
		pend = 1'b0;
		if (is_ctl_instr(ifetch_instr) && ifetch_pred_taken) begin
			pend = 1'b1;
			ptgt = ifetch_pred_target;
		end
		present_pc(npc);
	endtask

	initial begin
		seed = 32'h104584fe;
		clk = 1'b0;
		rst = 1'b1;
		ifetch_valid = 1'b0;
		ifetch_pc = '0;
		ifetch_instr = '0;
		ifetch_pred_taken = 1'b0;
		ifetch_pred_target = '0;
		mem_wait = 1'b0;
		pend = 1'b0;
		ptgt = '0;
		hs_s = 1'b0;
		rd_s = 1'b0;
		rpc_s = '0;
		repeat (RST_CYCLES) @(posedge clk);
		#1 rst = 1'b0;
	end

	// ##################################################
	// fetch memory model
	always @(negedge clk) begin
		hs_s <= ifetch_valid & ifetch_ready;
		rd_s <= redirect_valid;
		rpc_s <= redirect_pc;
	end

	always @(posedge clk) begin
		logic [31:0] r;
		logic rst_at_edge;
		rst_at_edge = rst; // reset as the DUT sees it at this edge
		#1;
		if (rst_at_edge) begin
			ifetch_valid = 1'b0;
			pend = 1'b0;
		end else begin
			if (rd_s) begin
				pend = 1'b0;
				present_pc(rpc_s); // restart on the correct path
			end else if (hs_s || !ifetch_valid) begin
				if (ifetch_valid) begin
					advance_fetch();
				end else begin
					present_pc(32'd0);
				end
			end
			r = $random(seed);
			mem_wait = (r[1:0] == 2'd0);
		end
	end

	// ##################################################
	// end of run
	initial begin
		wait (chk_done === 1'b1);
		repeat (2) @(posedge clk);
		$display("errors: %0d, commits checked: %0d", errors, commits);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	initial begin
		#((TARGET * 200 + RST_CYCLES) * 10);
		$display("watchdog expired, only %0d of %0d commits seen", commits, TARGET);
		$display("errors: %0d, commits checked: %0d", errors, commits);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- hdl/branch_exec.sv
`include "cpu_defs_consts.svh"
`timescale 1ns/1ps

module branch_exec (
	input  logic clk_i,
	input  logic rst_i,
	input  exec_pkg::pipeline_exec_t [1:0] id_i,
	input  logic stall_i, // EX held, MM gets a bubble
	input  logic mm_stall_i,
	output exec_pkg::pipeline_exec_t [1:0] ex_o,
	output exec_pkg::branch_resolved_t [1:0] resolved_o,
	output logic stall_req_o
);
	import exec_pkg::*;

	pipeline_exec_t [1:0] ex_q;
	logic [1:0] mul_cnt_q;
	logic has_mul;

	function automatic branch_resolved_t resolve(input pipeline_exec_t p);
		branch_resolved_t r;
		logic [`ADDR_W-1:0] pc4;
		logic [`ADDR_W-1:0] dest;
		logic [15:0] imm;
		logic rs_eq;
		pc4 = p.pc + 'd4;
		imm = p.instr[15:0];
		rs_eq = p.instr[25:21] == p.instr[20:16];
		r.valid = p.valid & ((p.op_class == OPC_BRANCH) | (p.op_class == OPC_JUMP));
		r.pc = p.pc;
		if (p.op_class == OPC_JUMP) begin
			r.taken = 1'b1;
			dest = {pc4[`ADDR_W-1:28], p.instr[25:0], 2'b00}; // region of the slot
		end else begin
			r.taken = (p.instr[31:26] == `OP_BNE) ? !rs_eq : rs_eq;
			dest = pc4 + {{(`ADDR_W-18){imm[15]}}, imm, 2'b00};
		end
		r.mispredict = (r.taken != p.pred_taken) | (r.taken & (dest != p.pred_target));
		r.target = r.taken ? dest : p.pc + 'd8; // skip the delay slot
		return r;
	endfunction

	assign resolved_o[0] = resolve(id_i[0]);
	assign resolved_o[1] = resolve(id_i[1]);

	// ##################################################
	// multiply occupies EX for two extra cycles
	assign has_mul = (id_i[0].valid & (id_i[0].op_class == OPC_MUL)) |
		(id_i[1].valid & (id_i[1].op_class == OPC_MUL));
	assign stall_req_o = has_mul & (mul_cnt_q != 2'd2);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			mul_cnt_q <= 2'd0;
		end else if (!mm_stall_i) begin
			if (!stall_i) begin
				mul_cnt_q <= 2'd0; // pair leaves EX
			end else if (stall_req_o) begin
				mul_cnt_q <= mul_cnt_q + 2'd1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ex_q[0].valid <= 1'b0;
			ex_q[1].valid <= 1'b0;
		end else if (!mm_stall_i) begin
			if (stall_i) begin
				ex_q[0].valid <= 1'b0;
				ex_q[1].valid <= 1'b0;
			end else begin
				ex_q <= id_i;
			end
		end
	end

	assign ex_o = ex_q;

endmodule

//--- hdl/commit_stage.sv
`include "cpu_defs_consts.svh"
`timescale 1ns/1ps

module commit_stage (
	input  logic clk_i,
	input  logic rst_i,
	input  exec_pkg::pipeline_exec_t [1:0] ex_i,
	input  logic stall_i,
	input  logic mem_wait_i,
	output logic stall_req_o,
	output logic [1:0] commit_valid_o,
	output logic [`ADDR_W-1:0] commit_pc0_o,
	output logic [`ADDR_W-1:0] commit_pc1_o
);
	import exec_pkg::*;

	pipeline_exec_t [1:0] mm_q;
	logic [1:0] is_load;

	assign is_load[0] = mm_q[0].valid & (mm_q[0].op_class == OPC_LOAD);
	assign is_load[1] = mm_q[1].valid & (mm_q[1].op_class == OPC_LOAD);
	assign stall_req_o = mem_wait_i & (|is_load);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			mm_q[0].valid <= 1'b0;
			mm_q[1].valid <= 1'b0;
		end else if (!stall_i) begin
			mm_q <= ex_i;
		end
	end

	// retire only in the cycle the pair leaves, lane 0 is older
	assign commit_valid_o[0] = mm_q[0].valid & ~stall_i;
	assign commit_valid_o[1] = mm_q[1].valid & ~stall_i;
	assign commit_pc0_o = mm_q[0].pc;
	assign commit_pc1_o = mm_q[1].pc;

endmodule

//--- hdl/core_top.sv
`include "cpu_defs_consts.svh"
`timescale 1ns/1ps

module core_top (
	input  logic clk_i,
	input  logic rst_i,
	input  logic ifetch_valid_i,
	output logic ifetch_ready_o,
	input  logic [`ADDR_W-1:0] ifetch_pc_i,
	input  logic [31:0] ifetch_instr_i,
	input  logic ifetch_pred_taken_i,
	input  logic [`ADDR_W-1:0] ifetch_pred_target_i,
	output logic redirect_valid_o,
	output logic [`ADDR_W-1:0] redirect_pc_o,
	input  logic mem_wait_i,
	output logic [1:0] commit_valid_o,
	output logic [`ADDR_W-1:0] commit_pc0_o,
	output logic [`ADDR_W-1:0] commit_pc1_o
);
	import fetch_pkg::*;
	import exec_pkg::*;

	fetch_entry_t [`FETCH_NUM-1:0] fetch_entry;
	pipeline_exec_t [1:0] id_pipe;
	pipeline_exec_t [1:0] ex_pipe;
	branch_resolved_t [1:0] resolved_lane;
	branch_resolved_t resolved_sel;
	logic [1:0] pop_cnt;
	logic stall_if;
	logic stall_ex;
	logic stall_mm;
	logic flush_if;
	logic flush_id;
	logic stall_from_id;
	logic stall_from_ex;
	logic stall_from_mm;
	logic delayslot_not_exec;
	logic hold_resolved;

	// ##################################################
	// redirect leaves with the branch from EX
	assign redirect_valid_o = resolved_sel.valid & resolved_sel.mispredict & ~hold_resolved;
	assign redirect_pc_o = resolved_sel.target;

	fetch_queue i_fetch_queue (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.ifetch_valid_i(ifetch_valid_i),
		.ifetch_ready_o(ifetch_ready_o),
		.ifetch_pc_i(ifetch_pc_i),
		.ifetch_instr_i(ifetch_instr_i),
		.ifetch_pred_taken_i(ifetch_pred_taken_i),
		.ifetch_pred_target_i(ifetch_pred_target_i),
		.pop_cnt_i(pop_cnt),
		.stall_i(stall_if),
		.flush_i(flush_if),
		.redirect_i(redirect_valid_o),
		.keep_head_i(delayslot_not_exec),
		.fetch_entry_o(fetch_entry)
	);

	decode_issue i_decode_issue (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.fetch_entry_i(fetch_entry),
		.stall_i(stall_ex), // ID register feeds EX directly
		.flush_i(flush_id),
		.ex_busy_i({ex_pipe[1].valid, ex_pipe[0].valid, id_pipe[1].valid, id_pipe[0].valid}),
		.pop_cnt_o(pop_cnt),
		.stall_req_o(stall_from_id),
		.id_o(id_pipe)
	);

	branch_exec i_branch_exec (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.id_i(id_pipe),
		.stall_i(stall_ex),
		.mm_stall_i(stall_mm),
		.ex_o(ex_pipe),
		.resolved_o(resolved_lane),
		.stall_req_o(stall_from_ex)
	);

	pipeline_ctrl i_pipeline_ctrl (
		.rst_i(rst_i),
		.stall_from_id_i(stall_from_id),
		.stall_from_ex_i(stall_from_ex),
		.stall_from_mm_i(stall_from_mm),
		.stall_if_o(stall_if),
		.stall_id_o(),
		.stall_ex_o(stall_ex),
		.stall_mm_o(stall_mm),
		.flush_if_o(flush_if),
		.flush_id_o(flush_id),
		.flush_ex_o(),
		.flush_mm_o(),
		.fetch_entry_i(fetch_entry),
		.pipeline_exec_i(id_pipe), // pair being resolved
		.resolved_branch_i(resolved_lane),
		.resolved_branch_o(resolved_sel),
		.delayslot_not_exec_o(delayslot_not_exec),
		.hold_resolved_branch_o(hold_resolved)
	);

	commit_stage i_commit_stage (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.ex_i(ex_pipe),
		.stall_i(stall_mm),
		.mem_wait_i(mem_wait_i),
		.stall_req_o(stall_from_mm),
		.commit_valid_o(commit_valid_o),
		.commit_pc0_o(commit_pc0_o),
		.commit_pc1_o(commit_pc1_o)
	);

endmodule

//--- hdl/cpu_defs_consts.svh
`ifndef CPU_DEFS_CONSTS_SVH
`define CPU_DEFS_CONSTS_SVH

`define FETCH_NUM 2 // queue entries visible to decode
`define ADDR_W 32
`define FQ_DEPTH 8 // power of two, pointers wrap

// primary opcode field, instr[31:26]
`define OP_J 6'h02
`define OP_BEQ 6'h04
`define OP_BNE 6'h05
`define OP_MUL 6'h1c
`define OP_LW 6'h23
`define OP_SYNC 6'h3e

`endif

//--- hdl/decode_issue.sv
`include "cpu_defs_consts.svh"
`timescale 1ns/1ps

module decode_issue (
	input  logic clk_i,
	input  logic rst_i,
	input  fetch_pkg::fetch_entry_t [`FETCH_NUM-1:0] fetch_entry_i,
	input  logic stall_i, // EX stage stalled, register holds
	input  logic flush_i,
	input  logic [3:0] ex_busy_i,
	output logic [1:0] pop_cnt_o,
	output logic stall_req_o,
	output exec_pkg::pipeline_exec_t [1:0] id_o
);
	import fetch_pkg::*;
	import exec_pkg::*;

	pipeline_exec_t [1:0] id_q;
	op_class_t cls0;
	op_class_t cls1;
	logic [1:0] issue_cnt;

	function automatic op_class_t classify(input logic [31:0] instr);
		case (instr[31:26])
			`OP_BEQ, `OP_BNE: return OPC_BRANCH;
			`OP_J: return OPC_JUMP;
			`OP_MUL: return OPC_MUL;
			`OP_LW: return OPC_LOAD;
			`OP_SYNC: return OPC_SYNC;
			default: return OPC_PLAIN;
		endcase
	endfunction

	function automatic logic is_ctl(input op_class_t c);
		return (c == OPC_BRANCH) || (c == OPC_JUMP);
	endfunction

	function automatic pipeline_exec_t to_lane(input fetch_entry_t e, input op_class_t c,
		input logic v);
		pipeline_exec_t p;
		p.valid = v;
		p.pc = e.pc;
		p.instr = e.instr;
		p.op_class = c;
		p.pred_taken = e.pred_taken;
		p.pred_target = e.pred_target;
		return p;
	endfunction

	// ##################################################
	// pairing rules
	always_comb begin
		cls0 = classify(fetch_entry_i[0].instr);
		cls1 = classify(fetch_entry_i[1].instr);
		issue_cnt = 2'd0;
		if (fetch_entry_i[0].valid) begin
			issue_cnt = 2'd1;
			if (fetch_entry_i[1].valid && cls0 != OPC_SYNC && cls1 != OPC_SYNC &&
				!(is_ctl(cls0) && is_ctl(cls1))) begin
				issue_cnt = 2'd2;
			end
		end
	end

	assign stall_req_o = fetch_entry_i[0].valid & (cls0 == OPC_SYNC) & (|ex_busy_i);
	assign pop_cnt_o = (stall_i | flush_i | stall_req_o) ? 2'd0 : issue_cnt;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			id_q[0].valid <= 1'b0;
			id_q[1].valid <= 1'b0;
		end else if (!stall_i) begin
			if (flush_i || stall_req_o) begin // bubble into EX
				id_q[0].valid <= 1'b0;
				id_q[1].valid <= 1'b0;
			end else begin
				id_q[0] <= to_lane(fetch_entry_i[0], cls0, issue_cnt != 2'd0);
				id_q[1] <= to_lane(fetch_entry_i[1], cls1, issue_cnt == 2'd2);
			end
		end
	end

	assign id_o = id_q;

endmodule

//--- hdl/exec_pkg.sv
`include "cpu_defs_consts.svh"

package exec_pkg;

	typedef enum logic [2:0] {
		OPC_PLAIN,
		OPC_BRANCH, // beq / bne
		OPC_JUMP,
		OPC_MUL, // multi-cycle in EX
		OPC_LOAD, // may wait on memory
		OPC_SYNC // issues alone on an empty back end
	} op_class_t;

	// one lane of the ID, EX and MM registers
	typedef struct packed {
		logic valid;
		logic [`ADDR_W-1:0] pc;
		logic [31:0] instr;
		op_class_t op_class;
		logic pred_taken;
		logic [`ADDR_W-1:0] pred_target;
	} pipeline_exec_t;

	// outcome of one lane in EX
	typedef struct packed {
		logic valid; // lane holds a branch or jump
		logic [`ADDR_W-1:0] pc;
		logic taken;
		logic mispredict;
		logic [`ADDR_W-1:0] target; // next pc after the delay slot
	} branch_resolved_t;

endpackage

//--- hdl/fetch_pkg.sv
`include "cpu_defs_consts.svh"

package fetch_pkg;

	// one slot of the instruction queue
	typedef struct packed {
		logic valid;
		logic [`ADDR_W-1:0] pc;
		logic [31:0] instr;
		logic pred_taken; // front end guessed taken
		logic [`ADDR_W-1:0] pred_target;
	} fetch_entry_t;

endpackage

//--- hdl/fetch_queue.sv
`include "cpu_defs_consts.svh"
`timescale 1ns/1ps

module fetch_queue (
	input  logic clk_i,
	input  logic rst_i,
	input  logic ifetch_valid_i,
	output logic ifetch_ready_o,
	input  logic [`ADDR_W-1:0] ifetch_pc_i,
	input  logic [31:0] ifetch_instr_i,
	input  logic ifetch_pred_taken_i,
	input  logic [`ADDR_W-1:0] ifetch_pred_target_i,
	input  logic [1:0] pop_cnt_i,
	input  logic stall_i,
	input  logic flush_i,
	input  logic redirect_i,
	input  logic keep_head_i,
	output fetch_pkg::fetch_entry_t [`FETCH_NUM-1:0] fetch_entry_o
);
	import fetch_pkg::*;

	localparam int PTR_W = $clog2(`FQ_DEPTH);
	localparam int CNT_W = PTR_W + 1;

	fetch_entry_t mem_q [`FQ_DEPTH];
	fetch_entry_t push_entry;
	logic [PTR_W-1:0] head_q;
	logic [PTR_W-1:0] tail_q;
	logic [PTR_W-1:0] head_nxt;
	logic [CNT_W-1:0] cnt_q;
	logic push;
	logic keep;

	// a waiting delay slot may still enter while the front end is stalled
	assign ifetch_ready_o = (cnt_q != CNT_W'(`FQ_DEPTH)) & ~redirect_i &
		(~stall_i | keep_head_i);
	assign push = ifetch_valid_i & ifetch_ready_o;

	assign head_nxt = head_q + PTR_W'(pop_cnt_i);
	assign keep = (cnt_q != '0) & (pop_cnt_i == 2'd0); // head survives the redirect

	always_comb begin
		push_entry.valid = 1'b1;
		push_entry.pc = ifetch_pc_i;
		push_entry.instr = ifetch_instr_i;
		push_entry.pred_taken = ifetch_pred_taken_i;
		push_entry.pred_target = ifetch_pred_target_i;
	end

	// oldest entries first, only the head while a delay slot is pending
	always_comb begin
		for (int i = 0; i < `FETCH_NUM; i++) begin
			fetch_entry_o[i] = mem_q[head_q + PTR_W'(i)];
			fetch_entry_o[i].valid = (cnt_q > CNT_W'(i)) & ((i == 0) | ~keep_head_i);
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i || flush_i || (redirect_i && !keep_head_i)) begin
			head_q <= '0;
			tail_q <= '0;
			cnt_q <= '0;
		end else if (redirect_i) begin // head is the delay slot
			head_q <= head_nxt;
			tail_q <= head_nxt + PTR_W'(keep);
			cnt_q <= CNT_W'(keep);
		end else begin
			head_q <= head_nxt;
			tail_q <= tail_q + PTR_W'(push);
			cnt_q <= cnt_q + CNT_W'(push) - CNT_W'(pop_cnt_i);
		end
	end

	always_ff @(posedge clk_i) begin
		if (push) begin
			mem_q[tail_q] <= push_entry;
		end
	end

endmodule

//--- hdl/pipeline_ctrl.sv
`include "cpu_defs_consts.svh"
`timescale 1ns/1ps

module pipeline_ctrl (
	input  logic rst_i,
	input  logic stall_from_id_i,
	input  logic stall_from_ex_i,
	input  logic stall_from_mm_i,
	output logic stall_if_o,
	output logic stall_id_o,
	output logic stall_ex_o,
	output logic stall_mm_o,
	output logic flush_if_o,
	output logic flush_id_o,
	output logic flush_ex_o,
	output logic flush_mm_o,
	input  fetch_pkg::fetch_entry_t [`FETCH_NUM-1:0] fetch_entry_i,
	input  exec_pkg::pipeline_exec_t [1:0] pipeline_exec_i,
	input  exec_pkg::branch_resolved_t [1:0] resolved_branch_i,
	output exec_pkg::branch_resolved_t resolved_branch_o,
	output logic delayslot_not_exec_o, // slot of the mispredict is still in front
	output logic hold_resolved_branch_o
);

	logic [3:0] stall_vec; // if, id, ex, mm
	logic [1:0] mispredict;
	logic entry_avail;
	logic wait_slot;
	logic flush_front;

	assign mispredict[0] = resolved_branch_i[0].valid & resolved_branch_i[0].mispredict;
	assign mispredict[1] = resolved_branch_i[1].valid & resolved_branch_i[1].mispredict;

	always_comb begin
		entry_avail = 1'b0;
		for (int i = 0; i < `FETCH_NUM; i++) begin
			entry_avail = entry_avail | fetch_entry_i[i].valid;
		end
	end

	// lane 1 empty means the slot was never paired with the branch
	assign delayslot_not_exec_o = mispredict[1] | (mispredict[0] & ~pipeline_exec_i[1].valid);
	assign wait_slot = delayslot_not_exec_o & ~entry_avail;
	assign flush_front = (|mispredict) & ~delayslot_not_exec_o;

	// ##################################################
	// redirect source, the later lane wins
	always_comb begin
		resolved_branch_o = '0;
		if (!wait_slot) begin
			for (int i = 0; i < 2; i++) begin
				if (resolved_branch_i[i].valid) begin
					resolved_branch_o = resolved_branch_i[i];
				end
			end
		end
	end

	// ##################################################
	// stall priority, memory first
	always_comb begin
		stall_vec = 4'b0000;
		if (rst_i || stall_from_mm_i) begin
			stall_vec = 4'b1111;
		end else if (stall_from_ex_i || wait_slot) begin
			stall_vec = 4'b1110;
		end else if (stall_from_id_i) begin
			stall_vec = 4'b1100;
		end
	end

	assign stall_if_o = stall_vec[3];
	assign stall_id_o = stall_vec[2];
	assign stall_ex_o = stall_vec[1];
	assign stall_mm_o = stall_vec[0];

	assign flush_if_o = flush_front;
	assign flush_id_o = flush_front;
	assign flush_ex_o = 1'b0; // the branch itself always proceeds
	assign flush_mm_o = 1'b0;

	assign hold_resolved_branch_o = stall_vec[1] | stall_vec[0];

endmodule

//--- project.f
+incdir+hdl
+incdir+bench
hdl/fetch_pkg.sv
hdl/exec_pkg.sv
hdl/fetch_queue.sv
hdl/decode_issue.sv
hdl/branch_exec.sv
hdl/pipeline_ctrl.sv
hdl/commit_stage.sv
hdl/core_top.sv
bench/core_checker.sv
bench/tb_core.sv
